// File: project.f
+incdir+include
rtl/phy_cfg_pkg.sv
rtl/mii_pkg.sv
rtl/mii_crc32.sv
rtl/mii_tx_framer.sv
rtl/mii_rx_capture.sv
rtl/phy_apb_regs.sv
rtl/phy_model_top.sv
test/tb_phy_model.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the PHY model testbench with Verilator

set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f project.f --top-module tb_phy_model -Mdir "$BUILD_DIR" -o tb_phy_model
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/tb_phy_model" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -qF "*** TEST FAILED ***" "$LOG"; then
    echo "simulation reported failure, see $LOG"
    exit 1
fi
echo "simulation finished without failure"
exit 0

// File: include/tb_phy_tasks.svh
// ====================
// helper tasks and functions of the PHY model testbench
// included inside the testbench module, they use its signals and counters
// ====================

`ifndef TB_PHY_TASKS_SVH
`define TB_PHY_TASKS_SVH

task automatic compare_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp)
    begin
        $display("Mismatch at %0t: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
        errors++;
    end
endtask

// ====================
// APB access
// ====================
// setup, access, then one idle cycle; response sampled mid access cycle
task automatic apb_access(input logic wr, input apb_addr_t addr, input apb_data_t wdata,
                          output apb_data_t rdata, output logic err);
    @(posedge mtx_clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= wr;
    paddr   <= addr;
    pwdata  <= wdata;
    @(posedge mtx_clk);
    penable <= 1'b1;
    @(negedge mtx_clk);
    rdata = prdata;
    err   = pslverr;
    @(posedge mtx_clk);
    psel    <= 1'b0;
    penable <= 1'b0;
endtask

task automatic write_reg(input apb_addr_t addr, input apb_data_t data, input logic exp_err);
    apb_data_t rd;
    logic      err;
    apb_access(1'b1, addr, data, rd, err);
    compare_value($sformatf("pslverr on write 0x%02h", addr), 32'(err), 32'(exp_err));
endtask

task automatic read_reg(input apb_addr_t addr, output apb_data_t data, input logic exp_err);
    logic err;
    apb_access(1'b0, addr, '0, data, err);
    compare_value($sformatf("pslverr on read 0x%02h", addr), 32'(err), 32'(exp_err));
endtask

task automatic poll_status(input int bit_idx, input logic value, input string what);
    apb_data_t st;
    int        polls;
    polls = 0;
    read_reg(REG_STATUS, st, 1'b0);
    while ((st[bit_idx] != value) && (polls < MAX_POLLS))
    begin
        read_reg(REG_STATUS, st, 1'b0);
        polls++;
    end
    if (st[bit_idx] != value)
    begin
        $display("gave up waiting for %s after %0d status reads", what, MAX_POLLS);
        errors++;
    end
endtask

// ====================
// reference models
// ====================
// reflected Ethernet CRC-32, bitwise, result already complemented
function automatic logic [31:0] crc32_ref(input frame_buf_t bytes, input int len);
    logic [31:0] c;
    c = 32'hFFFF_FFFF;
    for (int i = 0; i < len; i++)
    begin
        c = c ^ {24'd0, bytes[i]};
        for (int b = 0; b < 8; b++)
            c = c[0] ? ((c >> 1) ^ 32'hEDB8_8320) : (c >> 1);
    end
    return ~c;
endfunction

// taps 32, 22, 2, 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
endfunction

task automatic random_byte(output byte_t b);
    for (int i = 0; i < 8; i++)
    begin
        lfsr_state = lfsr_next(lfsr_state);
        b[i] = lfsr_state[0];
    end
endtask

// ====================
// MII drive and monitor
// ====================
task automatic drive_rx_frame(input frame_buf_t bytes, input int len);
    for (int i = 0; i < NUM_PREAMBLE; i++)
    begin
        @(posedge mtx_clk);
        mrxdv <= 1'b1;
        mrxd  <= PRE_NIB;
    end
    @(posedge mtx_clk);
    mrxd <= SFD_NIB;
    for (int i = 0; i < len; i++)
    begin
        @(posedge mtx_clk);
        mrxd <= bytes[i][3:0];
        @(posedge mtx_clk);
        mrxd <= bytes[i][7:4];
    end
    @(posedge mtx_clk);
    mrxdv <= 1'b0;
    mrxd  <= '0;
endtask

// called on a falling edge with data valid high, returns when it drops
task automatic capture_tx_frame(output int n);
    n = 0;
    tx_nibs.delete();
    while (mtxdv && (n < MAX_NIBS))
    begin
        tx_nibs.push_back(mtxd);
        compare_value("mtxerr_o", 32'(mtxerr), 0);
        n++;
        @(negedge mtx_clk);
    end
endtask

`endif

// File: test/tb_phy_model.sv
// ====================
// directed testbench for the PHY-side MII model
// loads and sends a frame over APB, drives frames into the receive pins,
// and checks the MII nibbles, the FCS and the register responses
// ====================

`timescale 1ns/1ps

module tb_phy_model
    import phy_cfg_pkg::*, mii_pkg::*;
();

localparam int      CLK_HALF     = 20;
localparam int      RESET_CYCLES = 8;
localparam int      TX_LEN       = 20;
localparam int      RX1_LEN      = 12;
localparam int      RX2_LEN      = 8;
localparam int      NUM_PREAMBLE = 7;
localparam int      NUM_FCS      = 8;
localparam nibble_t PRE_NIB      = 4'h5;
localparam nibble_t SFD_NIB      = 4'hD;
localparam int      MAX_POLLS    = 40;
localparam int      MAX_NIBS     = 200;
localparam int      APB_CYCLES   = 3;
// each frame adds preamble, start nibble, FCS and a margin for gap and latency
localparam int      FRAME_EXTRA  = NUM_PREAMBLE + 1 + NUM_FCS + 32;
localparam int      TEST_CYCLES  = RESET_CYCLES + 3 * FRAME_EXTRA
                                 + 2 * (TX_LEN + RX1_LEN + RX2_LEN)
                                 + APB_CYCLES * (TX_LEN + RX1_LEN + 3 * MAX_POLLS + 20);
localparam int      TIMEOUT_CYCLES = 2 * TEST_CYCLES;

typedef byte_t frame_buf_t [64];

logic       mtx_clk = 1'b0;
logic       rst_n;
logic       psel;
logic       penable;
logic       pwrite;
apb_addr_t  paddr;
apb_data_t  pwdata;
nibble_t    mrxd;
logic       mrxdv;
apb_data_t  prdata;
logic       pready;
logic       pslverr;
nibble_t    mtxd;
logic       mtxdv;
logic       mtxerr;

int          errors;
int          checks;
int          cycles = 0;
logic [31:0] lfsr_state;
nibble_t     tx_nibs [$];
frame_buf_t  tx_frame;
frame_buf_t  rx_frame1;
frame_buf_t  rx_frame2;

`include "tb_phy_tasks.svh"

phy_model_top #(.BUF_DEPTH(64)) dut_i (
    .mtx_clk_i (mtx_clk),
    .rst_n_i   (rst_n),
    .psel_i    (psel),
    .penable_i (penable),
    .pwrite_i  (pwrite),
    .paddr_i   (paddr),
    .pwdata_i  (pwdata),
    .mrxd_i    (mrxd),
    .mrxdv_i   (mrxdv),
    .prdata_o  (prdata),
    .pready_o  (pready),
    .pslverr_o (pslverr),
    .mtxd_o    (mtxd),
    .mtxdv_o   (mtxdv),
    .mtxerr_o  (mtxerr)
);

always #CLK_HALF mtx_clk = ~mtx_clk;

always @(posedge mtx_clk)
begin
    cycles <= cycles + 1;
    if (cycles == TIMEOUT_CYCLES)
    begin
        $display("run stopped after %0d cycles, the tests did not finish", cycles);
        $display("*** TEST FAILED ***");
        $finish;
    end
end

// ====================
// directed tests
// ====================
task automatic after_reset();
    apb_data_t st;
    compare_value("mtxdv_o", 32'(mtxdv), 0);
    compare_value("mtxerr_o", 32'(mtxerr), 0);
    compare_value("mtxd_o", 32'(mtxd), 0);
    compare_value("pready_o", 32'(pready), 1);
    read_reg(REG_STATUS, st, 1'b0);
    compare_value("status[2:0]", 32'(st[2:0]), 0);
endtask

task automatic transmit_frame();
    apb_data_t   rd;
    logic [31:0] fcs;
    int          n;
    int          base;
    for (int i = 0; i < TX_LEN; i++)
        random_byte(tx_frame[i]);
    write_reg(REG_TX_LEN, TX_LEN, 1'b0);
    read_reg(REG_TX_LEN, rd, 1'b0);
    compare_value("tx length", rd, TX_LEN);
    for (int i = 0; i < TX_LEN; i++)
        write_reg(REG_TX_DATA, 32'(tx_frame[i]), 1'b0);
    write_reg(REG_CTRL, 1, 1'b0);
    // data valid rises on the second edge after the access cycle
    @(negedge mtx_clk);
    compare_value("mtxdv_o one cycle after start", 32'(mtxdv), 0);
    @(negedge mtx_clk);
    compare_value("mtxdv_o two cycles after start", 32'(mtxdv), 1);
    capture_tx_frame(n);
    compare_value("tx nibble count", n, NUM_PREAMBLE + 1 + 2 * TX_LEN + NUM_FCS);
    if (n == NUM_PREAMBLE + 1 + 2 * TX_LEN + NUM_FCS)
    begin
        for (int i = 0; i < NUM_PREAMBLE; i++)
            compare_value($sformatf("preamble nibble %0d", i), 32'(tx_nibs[i]), 32'(PRE_NIB));
        compare_value("start nibble", 32'(tx_nibs[NUM_PREAMBLE]), 32'(SFD_NIB));
        base = NUM_PREAMBLE + 1;
        for (int i = 0; i < TX_LEN; i++)
        begin
            compare_value($sformatf("byte %0d low nibble", i),
                          32'(tx_nibs[base + 2 * i]), 32'(tx_frame[i][3:0]));
            compare_value($sformatf("byte %0d high nibble", i),
                          32'(tx_nibs[base + 2 * i + 1]), 32'(tx_frame[i][7:4]));
        end
        fcs  = crc32_ref(tx_frame, TX_LEN);
        base = base + 2 * TX_LEN;
        for (int k = 0; k < NUM_FCS; k++)
            compare_value($sformatf("fcs nibble %0d", k), 32'(tx_nibs[base + k]),
                          32'(fcs[4 * k +: 4]));
    end
endtask

task automatic apb_error_responses();
    apb_data_t rd;
    // the previous frame is still in its gap here
    write_reg(REG_CTRL, 1, 1'b1);
    poll_status(0, 1'b0, "tx busy to clear");
    write_reg(REG_TX_LEN, 0, 1'b0);
    write_reg(REG_CTRL, 1, 1'b1);
    read_reg(8'h20, rd, 1'b1);
    write_reg(8'h3C, 32'h5A, 1'b1);
    // a refused start launches nothing
    read_reg(REG_STATUS, rd, 1'b0);
    compare_value("status tx busy", 32'(rd[0]), 0);
    @(negedge mtx_clk);
    compare_value("mtxdv_o after refused start", 32'(mtxdv), 0);
endtask

task automatic receive_frame();
    apb_data_t rd;
    for (int i = 0; i < RX1_LEN; i++)
        random_byte(rx_frame1[i]);
    drive_rx_frame(rx_frame1, RX1_LEN);
    poll_status(1, 1'b1, "rx ready");
    read_reg(REG_STATUS, rd, 1'b0);
    compare_value("rx length", 32'(rd[26:16]), RX1_LEN);
    compare_value("rx overrun", 32'(rd[2]), 0);
    // the rest of the frame is read back after the overrun frame
    for (int i = 0; i < RX1_LEN / 2; i++)
    begin
        read_reg(REG_RX_DATA, rd, 1'b0);
        compare_value($sformatf("rx byte %0d", i), rd, 32'(rx_frame1[i]));
    end
endtask

task automatic receive_overrun();
    apb_data_t rd;
    for (int i = 0; i < RX2_LEN; i++)
        random_byte(rx_frame2[i]);
    drive_rx_frame(rx_frame2, RX2_LEN);
    poll_status(2, 1'b1, "rx overrun");
    read_reg(REG_STATUS, rd, 1'b0);
    compare_value("rx ready while held", 32'(rd[1]), 1);
    compare_value("rx length while held", 32'(rd[26:16]), RX1_LEN);
    for (int i = RX1_LEN / 2; i < RX1_LEN; i++)
    begin
        read_reg(REG_RX_DATA, rd, 1'b0);
        compare_value($sformatf("rx byte %0d", i), rd, 32'(rx_frame1[i]));
    end
    write_reg(REG_RX_ACK, 1, 1'b0);
    read_reg(REG_STATUS, rd, 1'b0);
    compare_value("rx ready and overrun after ack", 32'(rd[2:1]), 0);
endtask

initial
begin
    rst_n      <= 1'b0;
    psel       <= 1'b0;
    penable    <= 1'b0;
    pwrite     <= 1'b0;
    paddr      <= '0;
    pwdata     <= '0;
    mrxd       <= '0;
    mrxdv      <= 1'b0;
    errors     = 0;
    checks     = 0;
    lfsr_state = 32'd67343;
    repeat (RESET_CYCLES) @(posedge mtx_clk);
    rst_n <= 1'b1;
    @(negedge mtx_clk);
    after_reset();
    transmit_frame();
    apb_error_responses();
    receive_frame();
    receive_overrun();
    $display("checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0)
        $display("*** TEST PASSED ***");
    else
        $display("*** TEST FAILED ***");
    $finish;
end

endmodule

// File: rtl/phy_model_top.sv
// ====================
// PHY-side MII model, top level
// APB pins are packed into one request, the MII transmit struct is
// unpacked onto the tx pins
// ====================

`timescale 1ns/1ps

module phy_model_top
    import phy_cfg_pkg::*, mii_pkg::*;
#(
    parameter int BUF_DEPTH = DEF_BUF_DEPTH
)
(
    input  logic      mtx_clk_i,
    input  logic      rst_n_i,
    input  logic      psel_i,
    input  logic      penable_i,
    input  logic      pwrite_i,
    input  apb_addr_t paddr_i,
    input  apb_data_t pwdata_i,
    input  nibble_t   mrxd_i,
    input  logic      mrxdv_i,
    output apb_data_t prdata_o,
    output logic      pready_o,
    output logic      pslverr_o,
    output nibble_t   mtxd_o,
    output logic      mtxdv_o,
    output logic      mtxerr_o
);

apb_req_t  apb_req;
tx_cmd_t   tx_cmd;
byte_t     tx_rd_data;
buf_addr_t tx_rd_addr;
logic      tx_busy;
mii_tx_t   mii_tx;
rx_wr_t    rx_wr;
rx_done_t  rx_done;
logic      rx_hold;

assign apb_req.psel    = psel_i;
assign apb_req.penable = penable_i;
assign apb_req.pwrite  = pwrite_i;
assign apb_req.paddr   = paddr_i;
assign apb_req.pwdata  = pwdata_i;

// no wait states
assign pready_o = 1'b1;

assign mtxd_o   = mii_tx.txd;
assign mtxdv_o  = mii_tx.txdv;
assign mtxerr_o = mii_tx.txer;

phy_apb_regs #(.BUF_DEPTH(BUF_DEPTH)) u_regs (
    .mtx_clk_i    (mtx_clk_i),
    .rst_n_i      (rst_n_i),
    .apb_i        (apb_req),
    .tx_busy_i    (tx_busy),
    .tx_rd_addr_i (tx_rd_addr),
    .rx_wr_i      (rx_wr),
    .rx_done_i    (rx_done),
    .prdata_o     (prdata_o),
    .pslverr_o    (pslverr_o),
    .tx_cmd_o     (tx_cmd),
    .tx_rd_data_o (tx_rd_data),
    .rx_hold_o    (rx_hold)
);

mii_tx_framer u_framer (
    .mtx_clk_i    (mtx_clk_i),
    .rst_n_i      (rst_n_i),
    .tx_cmd_i     (tx_cmd),
    .tx_rd_data_i (tx_rd_data),
    .tx_rd_addr_o (tx_rd_addr),
    .tx_busy_o    (tx_busy),
    .mii_tx_o     (mii_tx)
);

mii_rx_capture #(.BUF_DEPTH(BUF_DEPTH)) u_capture (
    .mtx_clk_i (mtx_clk_i),
    .rst_n_i   (rst_n_i),
    .mrxd_i    (mrxd_i),
    .mrxdv_i   (mrxdv_i),
    .rx_hold_i (rx_hold),
    .rx_wr_o   (rx_wr),
    .rx_done_o (rx_done)
);

endmodule

// File: rtl/phy_apb_regs.sv
// ====================
// APB slave of the PHY model, zero wait states
// holds the transmit and receive buffers, the tx length and the rx status,
// and issues the one-cycle transmit start to the framer
// ====================

`timescale 1ns/1ps

module phy_apb_regs
    import phy_cfg_pkg::*, mii_pkg::*;
#(
    parameter int BUF_DEPTH = DEF_BUF_DEPTH
)
(
    input  logic       mtx_clk_i,
    input  logic       rst_n_i,
    input  apb_req_t   apb_i,
    input  logic       tx_busy_i,
    input  buf_addr_t  tx_rd_addr_i,
    input  rx_wr_t     rx_wr_i,
    input  rx_done_t   rx_done_i,
    output apb_data_t  prdata_o,
    output logic       pslverr_o,
    output tx_cmd_t    tx_cmd_o,
    output byte_t      tx_rd_data_o,
    output logic       rx_hold_o
);

localparam int PTR_W = $clog2(BUF_DEPTH);

byte_t      tx_mem [BUF_DEPTH];
byte_t      rx_mem [BUF_DEPTH];
byte_t      tx_rd_q;

buf_addr_t  tx_wr_ptr_q;
frame_len_t tx_len_q;
buf_addr_t  rx_rd_ptr_q;
frame_len_t rx_len_q;
logic       rx_ready_q;
logic       rx_ovr_q;

logic       access;
logic       start;
logic       len_wr;
logic       tx_push;
logic       rx_pop;
logic       rx_ack;

// ====================
// access decode
// ====================
assign access = apb_i.psel && apb_i.penable;

always_comb
begin
    start    = 1'b0;
    len_wr   = 1'b0;
    tx_push  = 1'b0;
    rx_pop   = 1'b0;
    rx_ack   = 1'b0;
    prdata_o = '0;
    pslverr_o = 1'b0;
    if (access)
    begin
        case (apb_i.paddr)
            REG_CTRL:
                if (apb_i.pwrite && apb_i.pwdata[0])
                begin
                    // no restart of a running frame, no empty frames
                    pslverr_o = tx_busy_i || (tx_len_q == '0);
                    start     = !pslverr_o;
                end
            REG_STATUS:
                if (!apb_i.pwrite)
                    prdata_o = {5'd0, rx_len_q, 13'd0, rx_ovr_q, rx_ready_q, tx_busy_i};
            REG_TX_LEN:
                if (apb_i.pwrite)
                    len_wr = 1'b1;
                else
                    prdata_o = {21'd0, tx_len_q};
            REG_TX_DATA:
                if (apb_i.pwrite)
                begin
                    pslverr_o = tx_wr_ptr_q >= buf_addr_t'(BUF_DEPTH);
                    tx_push   = !pslverr_o;
                end
            REG_RX_DATA:
                if (!apb_i.pwrite)
                begin
                    prdata_o = {24'd0, rx_mem[rx_rd_ptr_q[PTR_W-1:0]]};
                    rx_pop   = 1'b1;
                end
            REG_RX_ACK:
                rx_ack = apb_i.pwrite;
            default:
                pslverr_o = 1'b1;
        endcase
    end
end

assign tx_cmd_o.start = start;
assign tx_cmd_o.len   = tx_len_q;
assign tx_rd_data_o   = tx_rd_q;
assign rx_hold_o      = rx_ready_q;

// ====================
// control and status
// ====================
always_ff @(posedge mtx_clk_i)
begin
    if (!rst_n_i)
    begin
        tx_wr_ptr_q <= '0;
        tx_len_q    <= '0;
        rx_rd_ptr_q <= '0;
        rx_len_q    <= '0;
        rx_ready_q  <= 1'b0;
        rx_ovr_q    <= 1'b0;
    end
    else
    begin
        // the next frame is loaded from byte zero again
        if (start)
            tx_wr_ptr_q <= '0;
        else if (tx_push)
            tx_wr_ptr_q <= tx_wr_ptr_q + buf_addr_t'(1);
        if (len_wr)
            tx_len_q <= apb_i.pwdata[10:0];
        if (rx_pop)
            rx_rd_ptr_q <= rx_rd_ptr_q + buf_addr_t'(1);
        // a frame finishing while the previous one is unread is lost
        if (rx_done_i.valid)
        begin
            if (rx_ready_q)
                rx_ovr_q <= 1'b1;
            else
            begin
                rx_ready_q <= 1'b1;
                rx_len_q   <= rx_done_i.len;
            end
        end
        if (rx_ack)
        begin
            rx_ready_q  <= 1'b0;
            rx_ovr_q    <= 1'b0;
            rx_rd_ptr_q <= '0;
        end
    end
end

// buffers, tx side read back one cycle after the framer's address
always_ff @(posedge mtx_clk_i)
begin
    if (tx_push)
        tx_mem[tx_wr_ptr_q[PTR_W-1:0]] <= apb_i.pwdata[7:0];
    if (rx_wr_i.valid)
        rx_mem[rx_wr_i.addr[PTR_W-1:0]] <= rx_wr_i.data;
    tx_rd_q <= tx_mem[tx_rd_addr_i[PTR_W-1:0]];
end

// start only from idle, and the framer must report busy right after
assert property (@(posedge mtx_clk_i) disable iff (!rst_n_i)
    tx_cmd_o.start |-> !tx_busy_i);
assert property (@(posedge mtx_clk_i) disable iff (!rst_n_i)
    tx_cmd_o.start |=> tx_busy_i);

endmodule

// File: rtl/mii_rx_capture.sv
// ====================
// MII receive capture
// skips the preamble, packs nibble pairs into buffer writes and reports
// the frame length once data valid drops
// ====================

`timescale 1ns/1ps

module mii_rx_capture
    import phy_cfg_pkg::*, mii_pkg::*;
#(
    parameter int BUF_DEPTH = DEF_BUF_DEPTH
)
(
    input  logic     mtx_clk_i,
    input  logic     rst_n_i,
    input  nibble_t  mrxd_i,
    input  logic     mrxdv_i,
    input  logic     rx_hold_i,
    output rx_wr_t   rx_wr_o,
    output rx_done_t rx_done_o
);

rx_state_e state_q;
nibble_t   lo_q;
buf_addr_t cnt_q;
logic      drop_q;
logic      in_buf;
rx_wr_t    wr_q;
rx_done_t  done_q;

assign in_buf = cnt_q < buf_addr_t'(BUF_DEPTH);

always_ff @(posedge mtx_clk_i)
begin
    if (!rst_n_i)
    begin
        state_q <= RX_IDLE;
        lo_q    <= '0;
        cnt_q   <= '0;
        drop_q  <= 1'b0;
        wr_q    <= '0;
        done_q  <= '0;
    end
    else
    begin
        wr_q.valid   <= 1'b0;
        done_q.valid <= 1'b0;
        // once the buffer is held, the whole frame is dropped
        drop_q <= (state_q == RX_IDLE) ? rx_hold_i : (drop_q | rx_hold_i);
        case (state_q)
            RX_IDLE:
            begin
                cnt_q <= '0;
                if (mrxdv_i)
                    state_q <= (mrxd_i == MII_SFD_NIB) ? RX_LO : RX_PREAMBLE;
            end
            RX_PREAMBLE:
                if (!mrxdv_i)
                    state_q <= RX_IDLE;
                else if (mrxd_i == MII_SFD_NIB)
                    state_q <= RX_LO;
            RX_LO:
            begin
                lo_q    <= mrxd_i;
                state_q <= mrxdv_i ? RX_HI : RX_DONE;
            end
            RX_HI:
                if (mrxdv_i)
                begin
                    wr_q.valid <= !drop_q && !rx_hold_i && in_buf;
                    wr_q.addr  <= cnt_q;
                    wr_q.data  <= {mrxd_i, lo_q};
                    // length saturates at the buffer depth
                    if (in_buf)
                        cnt_q <= cnt_q + buf_addr_t'(1);
                    state_q <= RX_LO;
                end
                else
                    state_q <= RX_DONE;
            RX_DONE:
            begin
                done_q.valid <= !drop_q || rx_hold_i;
                done_q.len   <= cnt_q;
                state_q      <= RX_IDLE;
            end
            default:
                state_q <= RX_IDLE;
        endcase
    end
end

assign rx_wr_o   = wr_q;
assign rx_done_o = done_q;

assert property (@(posedge mtx_clk_i) disable iff (!rst_n_i)
    rx_wr_o.valid |-> rx_wr_o.addr < buf_addr_t'(BUF_DEPTH));

endmodule

// File: rtl/mii_tx_framer.sv
// ====================
// MII transmit framer, one nibble per cycle on registered outputs
// sends preamble, start nibble, payload low nibble first, then the FCS
// and holds tx busy through the inter-frame gap
// ====================

`timescale 1ns/1ps

module mii_tx_framer
    import phy_cfg_pkg::*, mii_pkg::*;
(
    input  logic       mtx_clk_i,
    input  logic       rst_n_i,
    input  tx_cmd_t    tx_cmd_i,
    input  byte_t      tx_rd_data_i,
    output buf_addr_t  tx_rd_addr_o,
    output logic       tx_busy_o,
    output mii_tx_t    mii_tx_o
);

tx_state_e  state_q;
logic [4:0] cnt_q;
frame_len_t len_q;
buf_addr_t  rd_addr_q;
byte_t      cur_byte_q;
mii_tx_t    mii_tx_q;

logic       crc_init;
logic       crc_en;
nibble_t    crc_nib;
crc_t       crc;
crc_t       crc_refl;
nibble_t    fcs_nib;

// remainder is preset on the start nibble and advances with each data nibble
assign crc_init = (state_q == TX_SFD);
assign crc_en   = (state_q == TX_LO) || (state_q == TX_HI);
assign crc_nib  = (state_q == TX_HI) ? cur_byte_q[7:4] : cur_byte_q[3:0];

mii_crc32 u_crc (
    .mtx_clk_i (mtx_clk_i),
    .rst_n_i   (rst_n_i),
    .init_i    (crc_init),
    .enable_i  (crc_en),
    .data_i    (crc_nib),
    .crc_o     (crc)
);

// x^31 goes out first, so nibble k carries reversed bits 31-4k down
always_comb
begin
    for (int i = 0; i < 32; i++)
        crc_refl[i] = crc[31-i];
end

assign fcs_nib = ~crc_refl[{cnt_q[2:0], 2'b00} +: 4];

// ====================
// frame sequencer
// ====================
always_ff @(posedge mtx_clk_i)
begin
    if (!rst_n_i)
    begin
        state_q    <= TX_IDLE;
        cnt_q      <= '0;
        len_q      <= '0;
        rd_addr_q  <= '0;
        cur_byte_q <= '0;
        mii_tx_q   <= '0;
    end
    else
    begin
        mii_tx_q.txer <= 1'b0;
        case (state_q)
            TX_IDLE:
            begin
                mii_tx_q.txd  <= '0;
                mii_tx_q.txdv <= 1'b0;
                if (tx_cmd_i.start)
                begin
                    state_q   <= TX_PREAMBLE;
                    cnt_q     <= '0;
                    len_q     <= tx_cmd_i.len;
                    rd_addr_q <= '0;
                end
            end
            TX_PREAMBLE:
            begin
                mii_tx_q.txd  <= MII_PREAMBLE_NIB;
                mii_tx_q.txdv <= 1'b1;
                cnt_q         <= cnt_q + 5'd1;
                if (cnt_q == 5'(PREAMBLE_NIBS - 1))
                begin
                    state_q <= TX_SFD;
                    cnt_q   <= '0;
                end
            end
            TX_SFD:
            begin
                // byte 0 has been on the read port since the preamble
                mii_tx_q.txd <= MII_SFD_NIB;
                cur_byte_q   <= tx_rd_data_i;
                rd_addr_q    <= rd_addr_q + buf_addr_t'(1);
                state_q      <= TX_LO;
            end
            TX_LO:
            begin
                mii_tx_q.txd <= cur_byte_q[3:0];
                state_q      <= TX_HI;
            end
            TX_HI:
            begin
                mii_tx_q.txd <= cur_byte_q[7:4];
                if (rd_addr_q == len_q)
                begin
                    state_q <= TX_FCS;
                    cnt_q   <= '0;
                end
                else
                begin
                    cur_byte_q <= tx_rd_data_i;
                    rd_addr_q  <= rd_addr_q + buf_addr_t'(1);
                    state_q    <= TX_LO;
                end
            end
            TX_FCS:
            begin
                mii_tx_q.txd <= fcs_nib;
                cnt_q        <= cnt_q + 5'd1;
                if (cnt_q == 5'(FCS_NIBS - 1))
                begin
                    state_q <= TX_GAP;
                    cnt_q   <= '0;
                end
            end
            TX_GAP:
            begin
                mii_tx_q.txd  <= '0;
                mii_tx_q.txdv <= 1'b0;
                cnt_q         <= cnt_q + 5'd1;
                if (cnt_q == 5'(IFG_CYCLES))
                    state_q <= TX_IDLE;
            end
            default:
                state_q <= TX_IDLE;
        endcase
    end
end

assign tx_rd_addr_o = rd_addr_q;
assign tx_busy_o    = (state_q != TX_IDLE);
assign mii_tx_o     = mii_tx_q;

// data valid drops only on the first gap cycle, after the last FCS nibble
assert property (@(posedge mtx_clk_i) disable iff (!rst_n_i)
    $fell(mii_tx_q.txdv) |-> ($past(state_q) == TX_GAP) && ($past(cnt_q) == '0));

endmodule

// File: rtl/mii_crc32.sv
// ====================
// Ethernet CRC-32 over one nibble per clock
// data bit 0 enters first, the remainder is kept unreflected
// ====================

`timescale 1ns/1ps

module mii_crc32
    import mii_pkg::*;
(
    input  logic    mtx_clk_i,
    input  logic    rst_n_i,
    input  logic    init_i,
    input  logic    enable_i,
    input  nibble_t data_i,
    output crc_t    crc_o
);

localparam crc_t CRC_POLY = 32'h04C11DB7;

crc_t crc_q;
crc_t crc_next;

// four serial steps of the LFSR unrolled
always_comb
begin
    logic fb;
    crc_next = crc_q;
    for (int i = 0; i < 4; i++)
    begin
        fb       = crc_next[31] ^ data_i[i];
        crc_next = {crc_next[30:0], 1'b0} ^ (fb ? CRC_POLY : '0);
    end
end

always_ff @(posedge mtx_clk_i)
begin
    if (!rst_n_i || init_i)
        crc_q <= '1;
    else if (enable_i)
        crc_q <= crc_next;
end

assign crc_o = crc_q;

endmodule

// File: rtl/mii_pkg.sv
// ====================
// MII line types, framing constants, state encodings and the structs
// passed between the register block, the framer and the receive capture
// ====================

package mii_pkg;

    import phy_cfg_pkg::*;

    typedef logic [3:0]  nibble_t;
    typedef logic [7:0]  byte_t;
    typedef logic [31:0] crc_t;

    // line constants
    localparam nibble_t MII_PREAMBLE_NIB = 4'h5;
    localparam nibble_t MII_SFD_NIB      = 4'hD;

    localparam int PREAMBLE_NIBS = 7;
    localparam int FCS_NIBS      = 8;
    // idle cycles held after each transmitted frame
    localparam int IFG_CYCLES    = 24;

    typedef enum logic [2:0] {
        TX_IDLE, TX_PREAMBLE, TX_SFD, TX_LO, TX_HI, TX_FCS, TX_GAP
    } tx_state_e;

    typedef enum logic [2:0] {
        RX_IDLE, RX_PREAMBLE, RX_LO, RX_HI, RX_DONE
    } rx_state_e;

    // ====================
    // transfer structs
    // ====================
    typedef struct packed {
        nibble_t txd;
        logic    txdv;
        logic    txer;
    } mii_tx_t;

    typedef struct packed {
        logic       start;
        frame_len_t len;
    } tx_cmd_t;

    typedef struct packed {
        logic      valid;
        buf_addr_t addr;
        byte_t     data;
    } rx_wr_t;

    typedef struct packed {
        logic       valid;
        frame_len_t len;
    } rx_done_t;

endpackage

// File: rtl/phy_cfg_pkg.sv
// ====================
// register map, buffer limits and APB request types for the PHY model
// imported by the APB register block, the receive capture and the top level
// ====================

package phy_cfg_pkg;

    typedef logic [7:0]  apb_addr_t;
    typedef logic [31:0] apb_data_t;

    // byte index into a buffer, wide enough for the largest depth
    typedef logic [10:0] buf_addr_t;
    typedef logic [10:0] frame_len_t;

    // one APB request as seen by the slave
    typedef struct packed {
        logic      psel;
        logic      penable;
        logic      pwrite;
        apb_addr_t paddr;
        apb_data_t pwdata;
    } apb_req_t;

    // ====================
    // register map
    // ====================
    localparam apb_addr_t REG_CTRL    = 8'h00;
    // status: bit 0 tx busy, bit 1 rx ready, bit 2 rx overrun, 26:16 rx length
    localparam apb_addr_t REG_STATUS  = 8'h04;
    localparam apb_addr_t REG_TX_LEN  = 8'h08;
    localparam apb_addr_t REG_TX_DATA = 8'h0C;
    localparam apb_addr_t REG_RX_DATA = 8'h10;
    localparam apb_addr_t REG_RX_ACK  = 8'h14;

    localparam int DEF_BUF_DEPTH = 64;

endpackage
